/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_queue_state
FILELIST ?= queue_state.f
BUILD_DIR ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* queue_state.f */
rtl/queue_state_pkg.sv
rtl/mmio_request_decode.sv
rtl/queue_table.sv
rtl/queue_state_merge.sv
rtl/queue_state_top.sv
testbench/tb_queue_state.sv

/* rtl/mmio_request_decode.sv */
`default_nettype none

module mmio_request_decode #(
    parameter int NUM_QUEUES = 16,
    parameter int MMIO_ADDR_WIDTH = 18
) (
    input  wire logic                                        pcie_clk,
    input  wire logic                                        pcie_reset_n,
    input  wire logic [MMIO_ADDR_WIDTH-1:0]                  mmio_address,
    input  wire logic                                        mmio_write,
    input  wire logic                                        mmio_read,
    input  wire logic [queue_state_pkg::LINE_WIDTH-1:0]      mmio_writedata,
    input  wire logic [queue_state_pkg::LINE_BYTES-1:0]      mmio_byteenable,
    output logic [((NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1)-1:0] cmd_queue,
    output logic [queue_state_pkg::LINE_WIDTH-1:0]           cmd_line,
    output logic [queue_state_pkg::NUM_SLOTS_USED-1:0]       cmd_slot_wr,
    output logic                                             cmd_rd
);

    localparam int QUEUE_WIDTH = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;
    localparam int REG_BYTES = queue_state_pkg::REG_BYTES;

    logic [QUEUE_WIDTH-1:0] page_idx;
    logic                   reg_region;
    logic                   reg_read;
    logic                   rd_pending;
    logic [QUEUE_WIDTH-1:0] rd_queue;
    logic                   rd_req;
    logic [QUEUE_WIDTH-1:0] rd_req_queue;

    // queue index comes from the page bits
    assign page_idx = mmio_address[queue_state_pkg::PAGE_LSB +: QUEUE_WIDTH];

    // every queue page carries REG_REGION_LINES register lines,
    // anything above the last page has no responder
    assign reg_region = mmio_address[MMIO_ADDR_WIDTH-1:queue_state_pkg::LINE_LSB]
        < NUM_QUEUES * queue_state_pkg::REG_REGION_LINES;
    assign reg_read = mmio_read && reg_region;

    // new read or the one left waiting
    assign rd_req = reg_read || rd_pending;
    assign rd_req_queue = reg_read ? page_idx : rd_queue;

    ////////////////////////////////////////////////////////////
    // command flags, writes win over reads
    ////////////////////////////////////////////////////////////

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            cmd_slot_wr <= '0;
            cmd_rd <= 1'b0;
            rd_pending <= 1'b0;
        end else begin
            // a slot is written only with all four byte enables
            for (int s = 0; s < queue_state_pkg::NUM_SLOTS_USED; s++) begin
                cmd_slot_wr[s] <= mmio_write && (&mmio_byteenable[s*REG_BYTES +: REG_BYTES]);
            end
            cmd_rd <= rd_req && !mmio_write;
            rd_pending <= rd_req && mmio_write;
        end
    end

    always_ff @(posedge pcie_clk) begin
        cmd_line <= mmio_writedata;
        cmd_queue <= mmio_write ? page_idx : rd_req_queue;
        if (reg_read) begin
            rd_queue <= page_idx;
        end
    end

    // host keeps only one read in flight
    a_single_read: assert property (
        @(posedge pcie_clk) disable iff (!pcie_reset_n)
        rd_pending |-> !mmio_read
    ) else $error("mmio read arrived while another read is pending");

endmodule

`default_nettype wire

/* rtl/queue_state_merge.sv */
`default_nettype none

module queue_state_merge (
    input  wire logic                                       pcie_clk,
    input  wire logic                                       pcie_reset_n,
    input  wire logic                                       cmd_rd,
    input  wire logic                                       engine_rd_en,
    input  wire logic [queue_state_pkg::RING_IDX_WIDTH-1:0] dsc_host_tail,
    input  wire logic [queue_state_pkg::RING_IDX_WIDTH-1:0] dsc_host_head,
    input  wire logic [queue_state_pkg::REG_WIDTH-1:0]      dsc_host_l_addr,
    input  wire logic [queue_state_pkg::REG_WIDTH-1:0]      dsc_host_h_addr,
    input  wire logic [queue_state_pkg::RING_IDX_WIDTH-1:0] pkt_host_tail,
    input  wire logic [queue_state_pkg::RING_IDX_WIDTH-1:0] pkt_host_head,
    input  wire logic [queue_state_pkg::REG_WIDTH-1:0]      pkt_host_l_addr,
    input  wire logic [queue_state_pkg::REG_WIDTH-1:0]      pkt_host_h_addr,
    output logic [queue_state_pkg::LINE_WIDTH-1:0]          mmio_readdata,
    output logic                                            mmio_readdatavalid,
    output logic                                            engine_state_valid
);

    localparam int LAT = queue_state_pkg::TABLE_READ_LATENCY;
    localparam int RW = queue_state_pkg::REG_WIDTH;
    localparam int DSC = queue_state_pkg::DSC_SLOT_BASE;
    localparam int PKT = queue_state_pkg::PKT_SLOT_BASE;
    localparam int F_TAIL = queue_state_pkg::FIELD_TAIL;
    localparam int F_HEAD = queue_state_pkg::FIELD_HEAD;
    localparam int F_L_ADDR = queue_state_pkg::FIELD_L_ADDR;
    localparam int F_H_ADDR = queue_state_pkg::FIELD_H_ADDR;

    logic [LAT-1:0] host_rd_pipe;
    logic [LAT-1:0] eng_rd_pipe;

    // read enables follow the table latency
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            host_rd_pipe <= '0;
            eng_rd_pipe <= '0;
            mmio_readdatavalid <= 1'b0;
        end else begin
            host_rd_pipe <= {host_rd_pipe[LAT-2:0], cmd_rd};
            eng_rd_pipe <= {eng_rd_pipe[LAT-2:0], engine_rd_en};
            mmio_readdatavalid <= host_rd_pipe[LAT-1];
        end
    end

    // engine data comes straight from the tables
    assign engine_state_valid = eng_rd_pipe[LAT-1];

    // line assembly, unused upper slots read as zero
    always_ff @(posedge pcie_clk) begin
        mmio_readdata <= '0;
        mmio_readdata[(DSC + F_TAIL) * RW +: RW] <= RW'(dsc_host_tail);
        mmio_readdata[(DSC + F_HEAD) * RW +: RW] <= RW'(dsc_host_head);
        mmio_readdata[(DSC + F_L_ADDR) * RW +: RW] <= dsc_host_l_addr;
        mmio_readdata[(DSC + F_H_ADDR) * RW +: RW] <= dsc_host_h_addr;
        mmio_readdata[(PKT + F_TAIL) * RW +: RW] <= RW'(pkt_host_tail);
        mmio_readdata[(PKT + F_HEAD) * RW +: RW] <= RW'(pkt_host_head);
        mmio_readdata[(PKT + F_L_ADDR) * RW +: RW] <= pkt_host_l_addr;
        mmio_readdata[(PKT + F_H_ADDR) * RW +: RW] <= pkt_host_h_addr;
    end

endmodule

`default_nettype wire

/* rtl/queue_state_pkg.sv */
`default_nettype none

package queue_state_pkg;

    ////////////////////////////////////////////////////////////
    // host line layout
    ////////////////////////////////////////////////////////////

    localparam int LINE_WIDTH = 512;
    localparam int LINE_BYTES = LINE_WIDTH / 8;
    localparam int REG_WIDTH = 32;
    localparam int REG_BYTES = REG_WIDTH / 8;

    // field order inside one table's slot group
    localparam int FIELD_TAIL = 0;
    localparam int FIELD_HEAD = 1;
    localparam int FIELD_L_ADDR = 2;
    localparam int FIELD_H_ADDR = 3;
    localparam int FIELDS_PER_TABLE = 4;

    localparam int DSC_SLOT_BASE = 0;
    localparam int PKT_SLOT_BASE = DSC_SLOT_BASE + FIELDS_PER_TABLE;
    localparam int NUM_SLOTS_USED = 2 * FIELDS_PER_TABLE;

    ////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////

    // one 4 KiB page per queue
    localparam int PAGE_LSB = 12;
    localparam int LINE_LSB = 6;
    // register lines in each queue page
    localparam int REG_REGION_LINES = 64;

    // ring indices are kept at 16 bits
    localparam int RING_IDX_WIDTH = 16;
    localparam int TABLE_READ_LATENCY = 2;

endpackage

`default_nettype wire

/* rtl/queue_state_top.sv */
`default_nettype none

module queue_state_top #(
    parameter int NUM_QUEUES = 16,
    parameter int MMIO_ADDR_WIDTH = 18
) (
    input  wire logic                                        pcie_clk,
    input  wire logic                                        pcie_reset_n,
    input  wire logic [MMIO_ADDR_WIDTH-1:0]                  mmio_address,
    input  wire logic                                        mmio_write,
    input  wire logic                                        mmio_read,
    input  wire logic [queue_state_pkg::LINE_WIDTH-1:0]      mmio_writedata,
    input  wire logic [queue_state_pkg::LINE_BYTES-1:0]      mmio_byteenable,
    output logic [queue_state_pkg::LINE_WIDTH-1:0]           mmio_readdata,
    output logic                                             mmio_readdatavalid,
    input  wire logic                                        engine_rd_en,
    input  wire logic [((NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1)-1:0] engine_rd_queue,
    input  wire logic                                        engine_tail_wr_en,
    input  wire logic [((NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1)-1:0] engine_wr_queue,
    input  wire logic [queue_state_pkg::RING_IDX_WIDTH-1:0]  engine_dsc_tail_in,
    input  wire logic [queue_state_pkg::RING_IDX_WIDTH-1:0]  engine_pkt_tail_in,
    output logic                                             engine_state_valid,
    output logic [queue_state_pkg::RING_IDX_WIDTH-1:0]       engine_dsc_tail,
    output logic [queue_state_pkg::RING_IDX_WIDTH-1:0]       engine_dsc_head,
    output logic [2*queue_state_pkg::REG_WIDTH-1:0]          engine_dsc_buf_addr,
    output logic [queue_state_pkg::RING_IDX_WIDTH-1:0]       engine_pkt_tail,
    output logic [queue_state_pkg::RING_IDX_WIDTH-1:0]       engine_pkt_head,
    output logic [2*queue_state_pkg::REG_WIDTH-1:0]          engine_pkt_buf_addr
);

    localparam int QUEUE_WIDTH = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;
    localparam int RIW = queue_state_pkg::RING_IDX_WIDTH;
    localparam int RW = queue_state_pkg::REG_WIDTH;

    logic [QUEUE_WIDTH-1:0]                     cmd_queue;
    logic [queue_state_pkg::LINE_WIDTH-1:0]     cmd_line;
    logic [queue_state_pkg::NUM_SLOTS_USED-1:0] cmd_slot_wr;
    logic                                       cmd_rd;
    logic [RIW-1:0] dsc_host_tail;
    logic [RIW-1:0] dsc_host_head;
    logic [RW-1:0]  dsc_host_l_addr;
    logic [RW-1:0]  dsc_host_h_addr;
    logic [RIW-1:0] pkt_host_tail;
    logic [RIW-1:0] pkt_host_head;
    logic [RW-1:0]  pkt_host_l_addr;
    logic [RW-1:0]  pkt_host_h_addr;

    mmio_request_decode #(.NUM_QUEUES(NUM_QUEUES), .MMIO_ADDR_WIDTH(MMIO_ADDR_WIDTH)) decode (
        .pcie_clk, .pcie_reset_n, .mmio_address, .mmio_write, .mmio_read,
        .mmio_writedata, .mmio_byteenable,
        .cmd_queue, .cmd_line, .cmd_slot_wr, .cmd_rd
    );

    // descriptor and packet tables side by side
    queue_table #(.NUM_QUEUES(NUM_QUEUES), .SLOT_BASE(queue_state_pkg::DSC_SLOT_BASE)) dsc_table (
        .pcie_clk, .cmd_queue, .cmd_line, .cmd_slot_wr, .cmd_rd,
        .engine_rd_en, .engine_rd_queue, .engine_tail_wr_en, .engine_wr_queue,
        .engine_tail_in(engine_dsc_tail_in),
        .host_tail(dsc_host_tail), .host_head(dsc_host_head),
        .host_l_addr(dsc_host_l_addr), .host_h_addr(dsc_host_h_addr),
        .engine_tail(engine_dsc_tail), .engine_head(engine_dsc_head),
        .engine_buf_addr(engine_dsc_buf_addr)
    );

    queue_table #(.NUM_QUEUES(NUM_QUEUES), .SLOT_BASE(queue_state_pkg::PKT_SLOT_BASE)) pkt_table (
        .pcie_clk, .cmd_queue, .cmd_line, .cmd_slot_wr, .cmd_rd,
        .engine_rd_en, .engine_rd_queue, .engine_tail_wr_en, .engine_wr_queue,
        .engine_tail_in(engine_pkt_tail_in),
        .host_tail(pkt_host_tail), .host_head(pkt_host_head),
        .host_l_addr(pkt_host_l_addr), .host_h_addr(pkt_host_h_addr),
        .engine_tail(engine_pkt_tail), .engine_head(engine_pkt_head),
        .engine_buf_addr(engine_pkt_buf_addr)
    );

    queue_state_merge merge (
        .pcie_clk, .pcie_reset_n, .cmd_rd, .engine_rd_en,
        .dsc_host_tail, .dsc_host_head, .dsc_host_l_addr, .dsc_host_h_addr,
        .pkt_host_tail, .pkt_host_head, .pkt_host_l_addr, .pkt_host_h_addr,
        .mmio_readdata, .mmio_readdatavalid, .engine_state_valid
    );

endmodule

`default_nettype wire

/* rtl/queue_table.sv */
`default_nettype none

module queue_table #(
    parameter int NUM_QUEUES = 16,
    parameter int SLOT_BASE = 0
) (
    input  wire logic                                        pcie_clk,
    input  wire logic [((NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1)-1:0] cmd_queue,
    input  wire logic [queue_state_pkg::LINE_WIDTH-1:0]      cmd_line,
    input  wire logic [queue_state_pkg::NUM_SLOTS_USED-1:0]  cmd_slot_wr,
    input  wire logic                                        cmd_rd,
    input  wire logic                                        engine_rd_en,
    input  wire logic [((NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1)-1:0] engine_rd_queue,
    input  wire logic                                        engine_tail_wr_en,
    input  wire logic [((NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1)-1:0] engine_wr_queue,
    input  wire logic [queue_state_pkg::RING_IDX_WIDTH-1:0]  engine_tail_in,
    output logic [queue_state_pkg::RING_IDX_WIDTH-1:0]       host_tail,
    output logic [queue_state_pkg::RING_IDX_WIDTH-1:0]       host_head,
    output logic [queue_state_pkg::REG_WIDTH-1:0]            host_l_addr,
    output logic [queue_state_pkg::REG_WIDTH-1:0]            host_h_addr,
    output logic [queue_state_pkg::RING_IDX_WIDTH-1:0]       engine_tail,
    output logic [queue_state_pkg::RING_IDX_WIDTH-1:0]       engine_head,
    output logic [2*queue_state_pkg::REG_WIDTH-1:0]          engine_buf_addr
);

    localparam int RIW = queue_state_pkg::RING_IDX_WIDTH;
    localparam int RW = queue_state_pkg::REG_WIDTH;
    localparam int HEAD_SLOT = SLOT_BASE + queue_state_pkg::FIELD_HEAD;
    localparam int L_ADDR_SLOT = SLOT_BASE + queue_state_pkg::FIELD_L_ADDR;
    localparam int H_ADDR_SLOT = SLOT_BASE + queue_state_pkg::FIELD_H_ADDR;

    logic [RIW-1:0] tail_mem   [NUM_QUEUES];
    logic [RIW-1:0] head_mem   [NUM_QUEUES];
    logic [RW-1:0]  l_addr_mem [NUM_QUEUES];
    logic [RW-1:0]  h_addr_mem [NUM_QUEUES];

    logic [RIW-1:0] head_wr_data;
    logic [RIW-1:0] host_tail_r;
    logic [RIW-1:0] host_head_r;
    logic [RW-1:0]  host_l_addr_r;
    logic [RW-1:0]  host_h_addr_r;
    logic [RIW-1:0] eng_tail_r;
    logic [RIW-1:0] eng_head_r;
    logic [RIW-1:0] eng_head_r2;
    logic [RW-1:0]  eng_l_addr_r;
    logic [RW-1:0]  eng_h_addr_r;
    logic           byp_r;
    logic           byp_r2;
    logic [RIW-1:0] byp_head_r;
    logic [RIW-1:0] byp_head_r2;

    // host head keeps only the low ring bits
    assign head_wr_data = cmd_line[HEAD_SLOT*RW +: RIW];

    ////////////////////////////////////////////////////////////
    // host port
    ////////////////////////////////////////////////////////////

    // tail slot of the group is never written from the host
    always_ff @(posedge pcie_clk) begin
        if (cmd_slot_wr[HEAD_SLOT]) begin
            head_mem[cmd_queue] <= head_wr_data;
        end
        if (cmd_slot_wr[L_ADDR_SLOT]) begin
            l_addr_mem[cmd_queue] <= cmd_line[L_ADDR_SLOT*RW +: RW];
        end
        if (cmd_slot_wr[H_ADDR_SLOT]) begin
            h_addr_mem[cmd_queue] <= cmd_line[H_ADDR_SLOT*RW +: RW];
        end
        if (cmd_rd) begin
            host_tail_r <= tail_mem[cmd_queue];
            host_head_r <= head_mem[cmd_queue];
            host_l_addr_r <= l_addr_mem[cmd_queue];
            host_h_addr_r <= h_addr_mem[cmd_queue];
        end
        // output register, second cycle of latency
        host_tail <= host_tail_r;
        host_head <= host_head_r;
        host_l_addr <= host_l_addr_r;
        host_h_addr <= host_h_addr_r;
    end

    ////////////////////////////////////////////////////////////
    // engine port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge pcie_clk) begin
        if (engine_tail_wr_en) begin
            tail_mem[engine_wr_queue] <= engine_tail_in;
        end
        if (engine_rd_en) begin
            eng_tail_r <= tail_mem[engine_rd_queue];
            eng_head_r <= head_mem[engine_rd_queue];
            eng_l_addr_r <= l_addr_mem[engine_rd_queue];
            eng_h_addr_r <= h_addr_mem[engine_rd_queue];
        end
        engine_tail <= eng_tail_r;
        eng_head_r2 <= eng_head_r;
        engine_buf_addr <= {eng_h_addr_r, eng_l_addr_r};
    end

    // same-edge head write and engine read would return the stale head,
    // so the written value is carried along next to the read
    always_ff @(posedge pcie_clk) begin
        byp_r <= engine_rd_en && cmd_slot_wr[HEAD_SLOT] && (engine_rd_queue == cmd_queue);
        byp_head_r <= head_wr_data;
        byp_r2 <= byp_r;
        byp_head_r2 <= byp_head_r;
    end

    assign engine_head = byp_r2 ? byp_head_r2 : eng_head_r2;

    // the engine does not read and write tails in the same cycle
    a_engine_rd_wr_excl: assert property (
        @(posedge pcie_clk) !(engine_rd_en && engine_tail_wr_en)
    ) else $error("engine tail write collides with engine read");

endmodule

`default_nettype wire

/* testbench/tb_queue_state.sv */
`default_nettype none

module tb_queue_state;

    localparam int NUM_QUEUES = 16;
    localparam int MMIO_ADDR_WIDTH = 18;
    localparam int QW = $clog2(NUM_QUEUES);
    localparam int LW = queue_state_pkg::LINE_WIDTH;
    localparam int LB = queue_state_pkg::LINE_BYTES;
    localparam int RW = queue_state_pkg::REG_WIDTH;
    localparam int RB = queue_state_pkg::REG_BYTES;
    localparam int RIW = queue_state_pkg::RING_IDX_WIDTH;
    localparam int DSC = queue_state_pkg::DSC_SLOT_BASE;
    localparam int PKT = queue_state_pkg::PKT_SLOT_BASE;
    localparam int FT = queue_state_pkg::FIELD_TAIL;
    localparam int FH = queue_state_pkg::FIELD_HEAD;
    localparam int FL = queue_state_pkg::FIELD_L_ADDR;
    localparam int FA = queue_state_pkg::FIELD_H_ADDR;
    localparam int LINE_BITS = queue_state_pkg::PAGE_LSB - queue_state_pkg::LINE_LSB;
    localparam int ENG_W = 4 * RIW + 4 * RW;
    localparam int RESET_CYCLES = 5;
    // test lengths in operations
    localparam int N_HOST = 48;
    localparam int N_PRESSURE = 8;
    localparam int PRESSURE_WRITES = 6;
    localparam int N_ENGINE = 16;
    localparam int N_BYPASS = 16;
    localparam int TOTAL_OPS = 2 * NUM_QUEUES + 2 * N_HOST + N_HOST / 8
        + N_PRESSURE * (PRESSURE_WRITES + 2) + 3 * N_ENGINE + 2 * N_BYPASS;
    localparam int OP_CYCLE_BOUND = 20;

    logic                       pcie_clk;
    logic                       pcie_reset_n;
    logic [MMIO_ADDR_WIDTH-1:0] mmio_address;
    logic                       mmio_write;
    logic                       mmio_read;
    logic [LW-1:0]              mmio_writedata;
    logic [LB-1:0]              mmio_byteenable;
    logic [LW-1:0]              mmio_readdata;
    logic                       mmio_readdatavalid;
    logic                       engine_rd_en;
    logic [QW-1:0]              engine_rd_queue;
    logic                       engine_tail_wr_en;
    logic [QW-1:0]              engine_wr_queue;
    logic [RIW-1:0]             engine_dsc_tail_in;
    logic [RIW-1:0]             engine_pkt_tail_in;
    logic                       engine_state_valid;
    logic [RIW-1:0]             engine_dsc_tail;
    logic [RIW-1:0]             engine_dsc_head;
    logic [2*RW-1:0]            engine_dsc_buf_addr;
    logic [RIW-1:0]             engine_pkt_tail;
    logic [RIW-1:0]             engine_pkt_head;
    logic [2*RW-1:0]            engine_pkt_buf_addr;
    logic [ENG_W-1:0]           engine_state;

    // reference model with one word per line slot
    logic [RW-1:0]    model_slot [NUM_QUEUES][queue_state_pkg::NUM_SLOTS_USED];
    logic [31:0]      lfsr_state = 32'h74e18de2;
    string            test_name = "reset";
    logic             rd_outstanding;
    logic             eng_outstanding;
    logic [LW-1:0]    exp_line;
    logic [ENG_W-1:0] exp_engine;

    assign engine_state = {engine_dsc_tail, engine_dsc_head, engine_dsc_buf_addr,
                           engine_pkt_tail, engine_pkt_head, engine_pkt_buf_addr};

    queue_state_top #(.NUM_QUEUES(NUM_QUEUES), .MMIO_ADDR_WIDTH(MMIO_ADDR_WIDTH))
        i_queue_state_top (.*);

    initial begin
        pcie_clk = 1'b0;
        forever #2 pcie_clk = ~pcie_clk;
    end

    task automatic fail_run(input string what);
        $display("TEST FAILED");
        $display("%s", what);
        $fatal(1, "stopped at first error");
    endtask

    ////////////////////////////////////////////////////////////
    // random values and reference model
    ////////////////////////////////////////////////////////////

    // galois lfsr stepped once per bit taken
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'ha300_0000 : 32'h0);
        end
        return v;
    endfunction

    function automatic logic [LW-1:0] random_line();
        logic [LW-1:0] line;
        for (int k = 0; k < LW / 32; k++) begin
            line[k*32 +: 32] = 32'(take_bits(32));
        end
        return line;
    endfunction

    // some slots get all four enables and the rest stay random
    function automatic logic [LB-1:0] random_be();
        logic [LB-1:0] be;
        for (int b = 0; b < LB; b++) begin
            be[b] = 1'(take_bits(1));
        end
        for (int s = 0; s < LB / RB; s++) begin
            if (take_bits(1) != '0) begin
                be[s*RB +: RB] = '1;
            end
        end
        return be;
    endfunction

    // register line of a queue page or an address above the register region
    function automatic logic [MMIO_ADDR_WIDTH-1:0] reg_address(input logic [QW-1:0] q,
                                                               input logic [1:0] above);
        logic [MMIO_ADDR_WIDTH-1:0] addr;
        addr = '0;
        addr[queue_state_pkg::PAGE_LSB +: QW] = q;
        addr[queue_state_pkg::LINE_LSB +: LINE_BITS] = LINE_BITS'(take_bits(LINE_BITS));
        addr[MMIO_ADDR_WIDTH-1 -: 2] = above;
        return addr;
    endfunction

    function automatic void model_host_write(input logic [QW-1:0] q, input logic [LW-1:0] data,
                                             input logic [LB-1:0] be);
        int field;
        for (int s = 0; s < queue_state_pkg::NUM_SLOTS_USED; s++) begin
            field = s % queue_state_pkg::FIELDS_PER_TABLE;
            if (field != FT && &be[s*RB +: RB]) begin
                model_slot[q][s] = (field == FH) ? RW'(data[s*RW +: RIW]) : data[s*RW +: RW];
            end
        end
    endfunction

    function automatic logic [LW-1:0] expected_line(input logic [QW-1:0] q);
        logic [LW-1:0] line;
        line = '0;
        for (int s = 0; s < queue_state_pkg::NUM_SLOTS_USED; s++) begin
            line[s*RW +: RW] = model_slot[q][s];
        end
        return line;
    endfunction

    function automatic logic [ENG_W-1:0] expected_engine(input logic [QW-1:0] q);
        return {model_slot[q][DSC+FT][RIW-1:0], model_slot[q][DSC+FH][RIW-1:0],
                model_slot[q][DSC+FA], model_slot[q][DSC+FL],
                model_slot[q][PKT+FT][RIW-1:0], model_slot[q][PKT+FH][RIW-1:0],
                model_slot[q][PKT+FA], model_slot[q][PKT+FL]};
    endfunction

    ////////////////////////////////////////////////////////////
    // bus operations
    ////////////////////////////////////////////////////////////

    task automatic set_strobes(input logic wr, input logic rd, input logic erd, input logic ewr);
        mmio_write <= wr;
        mmio_read <= rd;
        engine_rd_en <= erd;
        engine_tail_wr_en <= ewr;
    endtask

    task automatic host_write(input logic [QW-1:0] q, input logic [LW-1:0] data,
                              input logic [LB-1:0] be, input logic with_read);
        @(posedge pcie_clk);
        set_strobes(1'b1, with_read, 1'b0, 1'b0);
        mmio_address <= reg_address(q, 2'b00);
        mmio_writedata <= data;
        mmio_byteenable <= be;
        if (with_read) begin
            rd_outstanding <= 1'b1;
        end
        model_host_write(q, data, be);
    endtask

    // expected line is taken once all earlier writes are in the model
    task automatic await_read(input logic [QW-1:0] q);
        @(posedge pcie_clk);
        set_strobes(1'b0, 1'b0, 1'b0, 1'b0);
        exp_line <= expected_line(q);
        while (!mmio_readdatavalid) begin
            @(posedge pcie_clk);
        end
        rd_outstanding <= 1'b0;
    endtask

    task automatic host_read(input logic [QW-1:0] q);
        @(posedge pcie_clk);
        set_strobes(1'b0, 1'b1, 1'b0, 1'b0);
        mmio_address <= reg_address(q, 2'b00);
        rd_outstanding <= 1'b1;
        await_read(q);
    endtask

    task automatic region_miss_read(input logic [QW-1:0] q);
        @(posedge pcie_clk);
        set_strobes(1'b0, 1'b1, 1'b0, 1'b0);
        mmio_address <= reg_address(q, 2'(take_bits(2)) | 2'b01);
        @(posedge pcie_clk);
        set_strobes(1'b0, 1'b0, 1'b0, 1'b0);
        // a register read would answer within four cycles
        repeat (8) @(posedge pcie_clk);
    endtask

    task automatic engine_tail_write(input logic [QW-1:0] q, input logic [RIW-1:0] dsc_tail,
                                     input logic [RIW-1:0] pkt_tail);
        @(posedge pcie_clk);
        set_strobes(1'b0, 1'b0, 1'b0, 1'b1);
        engine_wr_queue <= q;
        engine_dsc_tail_in <= dsc_tail;
        engine_pkt_tail_in <= pkt_tail;
        model_slot[q][DSC+FT] = RW'(dsc_tail);
        model_slot[q][PKT+FT] = RW'(pkt_tail);
    endtask

    task automatic engine_read(input logic [QW-1:0] q);
        @(posedge pcie_clk);
        set_strobes(1'b0, 1'b0, 1'b1, 1'b0);
        engine_rd_queue <= q;
        eng_outstanding <= 1'b1;
        exp_engine <= expected_engine(q);
        @(posedge pcie_clk);
        set_strobes(1'b0, 1'b0, 1'b0, 1'b0);
        while (!engine_state_valid) begin
            @(posedge pcie_clk);
        end
        eng_outstanding <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    a_read_expected: assert property (
        @(posedge pcie_clk) disable iff (!pcie_reset_n)
        mmio_readdatavalid |-> rd_outstanding
    ) else fail_run($sformatf("read response with no read outstanding in %s", test_name));

    a_read_line: assert property (
        @(posedge pcie_clk) disable iff (!pcie_reset_n)
        mmio_readdatavalid && rd_outstanding |-> mmio_readdata == exp_line
    ) else fail_run($sformatf("mismatch %s expected %h actual %h",
                              test_name, $sampled(exp_line), $sampled(mmio_readdata)));

    a_engine_expected: assert property (
        @(posedge pcie_clk) disable iff (!pcie_reset_n)
        engine_state_valid |-> eng_outstanding
    ) else fail_run($sformatf("engine state valid with no engine read in %s", test_name));

    a_engine_state: assert property (
        @(posedge pcie_clk) disable iff (!pcie_reset_n)
        engine_state_valid && eng_outstanding |-> engine_state == exp_engine
    ) else fail_run($sformatf("mismatch %s expected %h actual %h",
                              test_name, $sampled(exp_engine), $sampled(engine_state)));

    initial begin
        repeat (RESET_CYCLES + TOTAL_OPS * OP_CYCLE_BOUND) @(posedge pcie_clk);
        fail_run("watchdog expired before the test sequence finished");
    end

    initial begin
        logic [QW-1:0] q;
        logic [LB-1:0] be;
        pcie_reset_n <= 1'b0;
        set_strobes(1'b0, 1'b0, 1'b0, 1'b0);
        mmio_address <= '0;
        mmio_writedata <= '0;
        mmio_byteenable <= '0;
        engine_rd_queue <= '0;
        engine_wr_queue <= '0;
        engine_dsc_tail_in <= '0;
        engine_pkt_tail_in <= '0;
        rd_outstanding <= 1'b0;
        eng_outstanding <= 1'b0;
        exp_line <= '0;
        exp_engine <= '0;
        repeat (RESET_CYCLES) @(posedge pcie_clk);
        pcie_reset_n <= 1'b1;
        test_name = "reset_state";
        repeat (10) @(posedge pcie_clk);

        // every field gets a known value first
        test_name = "fill";
        for (int i = 0; i < NUM_QUEUES; i++) begin
            host_write(QW'(i), random_line(), '1, 1'b0);
            engine_tail_write(QW'(i), RIW'(take_bits(RIW)), RIW'(take_bits(RIW)));
        end

        test_name = "host_write_read";
        for (int i = 0; i < N_HOST; i++) begin
            q = QW'(take_bits(QW));
            host_write(q, random_line(), random_be(), 1'b0);
            host_read(q);
            if (i % 8 == 7) begin
                region_miss_read(q);
            end
        end

        test_name = "read_under_writes";
        for (int r = 0; r < N_PRESSURE; r++) begin
            q = QW'(take_bits(QW));
            host_write(q, random_line(), random_be(), 1'b1);
            for (int w = 0; w < PRESSURE_WRITES; w++) begin
                host_write((take_bits(1) != '0) ? q : QW'(take_bits(QW)), random_line(),
                           random_be(), 1'b0);
            end
            await_read(q);
        end

        test_name = "engine_tail";
        for (int r = 0; r < N_ENGINE; r++) begin
            q = QW'(take_bits(QW));
            engine_tail_write(q, RIW'(take_bits(RIW)), RIW'(take_bits(RIW)));
            engine_read(q);
            host_read(q);
        end

        // engine read lands on the edge that writes the heads
        // only heads are bypassed so the address words stay untouched here
        test_name = "head_bypass";
        for (int r = 0; r < N_BYPASS; r++) begin
            q = QW'(take_bits(QW));
            be = random_be();
            be[(DSC + FH) * RB +: RB] = '1;
            be[(PKT + FH) * RB +: RB] = '1;
            be[(DSC + FL) * RB +: 2 * RB] = '0;
            be[(PKT + FL) * RB +: 2 * RB] = '0;
            host_write(q, random_line(), be, 1'b0);
            engine_read(q);
        end

        test_name = "done";
        @(posedge pcie_clk);
        set_strobes(1'b0, 1'b0, 1'b0, 1'b0);
        repeat (8) @(posedge pcie_clk);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
